//--- Makefile
SRCS := $(shell cat files.f)

obj_dir/Vmem_sys_tb: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module mem_sys_tb -o Vmem_sys_tb

run: obj_dir/Vmem_sys_tb
	./obj_dir/Vmem_sys_tb | tee sim.log
	@grep -q "NO ERRORS" sim.log && ! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- dv/mem_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_tb import mem_map_pkg::*; ();

    localparam int x_bits = 6;
    localparam int y_bits = 5;
    localparam int ram_addr_w = 17;
    localparam int pix_words = 1 << (x_bits + y_bits);
    localparam int n_data = 300;
    localparam int n_fetch = 300;
    localparam int cycle_limit = 200 * (n_data + n_fetch);

    logic clk, rst;
    logic i_cyc, i_stb, i_ack;
    logic [word_w-1:0] i_adr, i_dat_r;
    logic d_cyc, d_stb, d_we, d_ack;
    logic [word_w-1:0] d_adr, d_dat_w, d_dat_r;
    logic tx_ready, tx_start_n;
    logic [7:0] tx_byte;
    logic [led_count-1:0] led;
    logic [x_bits-1:0] pix_x;
    logic [y_bits-1:0] pix_y;
    logic [word_w-1:0] pix_data;

    // reference model
    logic [word_w-1:0] mem_model [0:65535];
    bit written [0:65535];
    logic [word_w-1:0] pix_model [0:pix_words-1];
    bit pix_written [0:pix_words-1];
    logic [led_count-1:0] led_model;
    logic [7:0] byte_model;
    bit byte_valid;
    logic start_n_model;

    int checks, mismatches, other_errors, cycle_count;
    logic i_ack_q, d_ack_q;

    mem_sys_top #(.x_bits(x_bits), .y_bits(y_bits), .ram_addr_w(ram_addr_w)) dut (
        .clk(clk), .rst(rst),
        .i_cyc(i_cyc), .i_stb(i_stb), .i_adr(i_adr), .i_dat_r(i_dat_r), .i_ack(i_ack),
        .d_cyc(d_cyc), .d_stb(d_stb), .d_we(d_we), .d_adr(d_adr),
        .d_dat_w(d_dat_w), .d_dat_r(d_dat_r), .d_ack(d_ack),
        .tx_ready(tx_ready), .tx_byte(tx_byte), .tx_start_n(tx_start_n),
        .led(led), .pix_x(pix_x), .pix_y(pix_y), .pix_data(pix_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report;
        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            other_errors++;
            $display("timeout: traffic did not finish within %0d cycles", cycle_limit);
            report();
            $finish;
        end
    end

    // ack must be a single cycle, tied to its request, and never on both ports
    always @(negedge clk) begin
        if (rst) begin
            compare("i_ack and d_ack", i_ack && d_ack, 0);
            if (i_ack) compare("i_cyc and i_stb at i_ack", i_cyc && i_stb, 1);
            if (d_ack) compare("d_cyc and d_stb at d_ack", d_cyc && d_stb, 1);
            compare("i_ack held", i_ack && i_ack_q, 0);
            compare("d_ack held", d_ack && d_ack_q, 0);
        end
        i_ack_q = i_ack;
        d_ack_q = d_ack;
    end

    // called at a falling edge, returns at a falling edge with the port idle
    task automatic drive_data(input logic we, input logic [15:0] adr, input logic [15:0] wd,
                              output logic [15:0] rd);
        d_cyc = 1'b1;
        d_stb = 1'b1;
        d_we = we;
        d_adr = adr;
        d_dat_w = wd;
        do @(negedge clk); while (d_ack !== 1'b1);
        rd = d_dat_r;
        @(negedge clk);
        d_cyc = 1'b0;
        d_stb = 1'b0;
    endtask

    function automatic logic [15:0] pick_mem_addr();
        // mostly a small window so reads hit written words
        if ($urandom % 4 != 0) return 16'($urandom % 64);
        return 16'($urandom % 32'hF800);
    endfunction

    task automatic check_outputs;
        compare("led", led, led_model);
        compare("tx_start_n", tx_start_n, start_n_model);
        if (byte_valid) compare("tx_byte", tx_byte, byte_model);
    endtask

    task automatic scan_pixel(input logic [x_bits-1:0] x, input logic [y_bits-1:0] y);
        int idx;
        idx = (int'(y) << x_bits) + int'(x);
        pix_x = x;
        pix_y = y;
        @(negedge clk);
        if (pix_written[idx]) compare("pix_data", pix_data, pix_model[idx]);
    endtask

    task automatic write_pixel;
        logic [15:0] x, y, c, rd;
        x = 16'($urandom);
        y = 16'($urandom);
        c = 16'($urandom);
        drive_data(1'b1, pixel_adr, x, rd);
        drive_data(1'b1, pixel_adr, y, rd);
        drive_data(1'b1, pixel_adr, c, rd);
        // memory offset 2^16 + (y << x_bits) + x, kept relative to the region
        pix_model[(int'(y[y_bits-1:0]) << x_bits) + int'(x[x_bits-1:0])] = c;
        pix_written[(int'(y[y_bits-1:0]) << x_bits) + int'(x[x_bits-1:0])] = 1'b1;
        scan_pixel(x[x_bits-1:0], y[y_bits-1:0]);
    endtask

    task automatic raise_tx_ready;
        tx_ready = 1'b0;
        @(negedge clk);
        tx_ready = 1'b1;
        @(negedge clk);
        start_n_model = 1'b1;
        compare("tx_start_n after tx_ready rise", tx_start_n, start_n_model);
        tx_ready = 1'($urandom % 2);
    endtask

    task automatic data_loop;
        logic [15:0] adr, wd, rd;
        int kind, k;
        for (int n = 0; n < n_data; n++) begin
            kind = $urandom % 16;
            wd = 16'($urandom);
            if (kind < 5) begin
                adr = pick_mem_addr();
                drive_data(1'b1, adr, wd, rd);
                mem_model[adr] = wd;
                written[adr] = 1'b1;
            end else if (kind < 9) begin
                adr = pick_mem_addr();
                drive_data(1'b0, adr, 16'h0, rd);
                if (written[adr]) compare("d_dat_r", rd, mem_model[adr]);
            end else if (kind == 9) begin
                k = $urandom % led_count;
                drive_data(1'b1, 16'(led_first + k), wd, rd);
                led_model[k] = wd[0];
            end else if (kind == 10) begin
                drive_data(1'b1, uart_byte_adr, wd, rd);
                byte_model = wd[7:0];
                byte_valid = 1'b1;
                start_n_model = 1'b0;
            end else if (kind == 11) begin
                drive_data(1'b0, uart_status_adr, 16'h0, rd);
                compare("uart status read", rd, {15'h0, tx_ready});
            end else if (kind == 12) begin
                raise_tx_ready();
            end else if (kind == 13) begin
                write_pixel();
            end else if (kind == 14) begin
                // unmapped write, then read back the window word it might alias
                adr = 16'(32'hF80D + $urandom % 32'h7F3);
                drive_data(1'b1, adr, wd, rd);
                drive_data(1'b0, {10'h0, adr[5:0]}, 16'h0, rd);
                if (written[adr[5:0]]) compare("d_dat_r after unmapped write", rd,
                                               mem_model[adr[5:0]]);
            end else begin
                adr = 16'(32'hF80D + $urandom % 32'h7F3);
                drive_data(1'b0, adr, 16'h0, rd);
                compare("unmapped read", rd, 0);
                scan_pixel(x_bits'($urandom), y_bits'($urandom));
            end
            check_outputs();
            if ($urandom % 4 == 0) repeat (1 + $urandom % 3) @(negedge clk);
        end
    endtask

    task automatic fetch_loop;
        logic [15:0] adr, eff, rd;
        for (int n = 0; n < n_fetch; n++) begin
            if ($urandom % 8 == 0) adr = 16'(32'hF800 + $urandom % 2048);
            else adr = 16'($urandom % 64);
            // fetches above the cpu memory read word 0
            eff = (adr <= ram_last) ? adr : 16'h0000;
            i_cyc = 1'b1;
            i_stb = 1'b1;
            i_adr = adr;
            do @(negedge clk); while (i_ack !== 1'b1);
            rd = i_dat_r;
            if (written[eff]) compare("i_dat_r", rd, mem_model[eff]);
            @(negedge clk);
            i_cyc = 1'b0;
            i_stb = 1'b0;
            if ($urandom % 3 == 0) repeat (1 + $urandom % 4) @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(32'h3a04_d3b2));
        rst = 1'b0;
        i_cyc = 1'b0;
        i_stb = 1'b0;
        i_adr = '0;
        d_cyc = 1'b0;
        d_stb = 1'b0;
        d_we = 1'b0;
        d_adr = '0;
        d_dat_w = '0;
        tx_ready = 1'b0;
        pix_x = '0;
        pix_y = '0;
        led_model = '0;
        start_n_model = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        compare("d_ack after reset", d_ack, 0);
        compare("i_ack after reset", i_ack, 0);
        compare("tx_start_n after reset", tx_start_n, 1);
        compare("led after reset", led, 0);
        fork
            fetch_loop();
            data_loop();
        join
        report();
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/mem_map_pkg.sv
logic/word_ram.sv
logic/io_regs.sv
logic/pixel_writer.sv
logic/mem_map.sv
logic/mem_sys_top.sv
dv/mem_sys_tb.sv

//--- logic/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs import mem_map_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,

    // decoded strobe and offset from the sequencer
    input  wire                  io_we,
    input  wire  [3:0]           io_sel,
    input  wire  [word_w-1:0]    io_wdata,
    output logic [word_w-1:0]    io_rdata,

    // uart transmit side
    input  wire                  tx_ready,
    output logic [7:0]           tx_byte,
    output logic                 tx_start_n,

    output logic [led_count-1:0] led
);

    // offsets from led_first
    localparam logic [word_w-1:0] status_off = uart_status_adr - led_first;
    localparam logic [word_w-1:0] byte_off = uart_byte_adr - led_first;

    logic tx_ready_q;
    logic tx_rise;
    logic led_hit;
    logic byte_hit;

    assign tx_rise = tx_ready && !tx_ready_q;
    assign led_hit = io_we && (io_sel < led_count);
    assign byte_hit = io_we && (io_sel == byte_off[3:0]);

    always_ff @(posedge clk) begin
        if (!rst) begin
            led <= '0;
            tx_start_n <= 1'b1;
            // a line that is already high at reset is not a rise
            tx_ready_q <= 1'b1;
        end else begin
            tx_ready_q <= tx_ready;
            if (led_hit) begin
                led[io_sel] <= io_wdata[0];
            end
            if (tx_rise) begin
                tx_start_n <= 1'b1;
            end
            // a new byte wins over a rise in the same cycle
            if (byte_hit) begin
                tx_start_n <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_hit) begin
            tx_byte <= io_wdata[7:0];
        end
    end

    assign io_rdata = (io_sel == status_off[3:0]) ? {{(word_w-1){1'b0}}, tx_ready} : '0;

    // the sequencer only strobes the led, status and byte addresses
    a_sel_range: assert property (
        @(posedge clk) disable iff (!rst)
        io_we |-> (io_sel <= byte_off[3:0])
    );

endmodule

`default_nettype wire

//--- logic/mem_map.sv
`timescale 1ns/1ps
`default_nettype none

// one transaction at a time: idle -> access -> done -> idle
module mem_map import mem_map_pkg::*; #(
    parameter int unsigned x_bits = 6,
    parameter int unsigned y_bits = 5,
    parameter int unsigned ram_addr_w = 17
) (
    input  wire                   clk,
    input  wire                   rst,

    // instruction fetch port, read only
    input  wire                   i_cyc,
    input  wire                   i_stb,
    input  wire  [word_w-1:0]     i_adr,
    output logic [word_w-1:0]     i_dat_r,
    output logic                  i_ack,

    // data port
    input  wire                   d_cyc,
    input  wire                   d_stb,
    input  wire                   d_we,
    input  wire  [word_w-1:0]     d_adr,
    input  wire  [word_w-1:0]     d_dat_w,
    output logic [word_w-1:0]     d_dat_r,
    output logic                  d_ack,

    // memory port a
    output logic                  ram_en,
    output logic                  ram_we,
    output logic [ram_addr_w-1:0] ram_addr,
    output logic [word_w-1:0]     ram_wdata,
    input  wire  [word_w-1:0]     ram_rdata,

    // led and uart registers
    output logic                  io_we,
    output logic [3:0]            io_sel,
    output logic [word_w-1:0]     io_wdata,
    input  wire  [word_w-1:0]     io_rdata,

    // pixel writer
    output logic                  pix_we,
    output logic [word_w-1:0]     pix_wdata,
    input  wire                   pw_write,
    input  wire  [ram_addr_w-1:0] pw_addr,
    input  wire  [word_w-1:0]     pw_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_done
    } state_t;

    state_t state;
    // owner of the current or last transaction
    logic gnt_d;

    logic i_req;
    logic d_req;
    logic d_is_mem;
    logic d_is_io;
    logic d_is_pix;
    logic [word_w-1:0] io_off;
    logic [ram_addr_w-1:0] fetch_addr;

    assign i_req = i_cyc && i_stb;
    assign d_req = d_cyc && d_stb;

    // region decode of the held data address
    assign d_is_mem = d_adr <= ram_last;
    assign d_is_io = (d_adr >= led_first) && (d_adr <= uart_byte_adr);
    assign d_is_pix = d_adr == pixel_adr;

    // fetches outside the cpu memory read word 0
    assign fetch_addr = (i_adr <= ram_last) ? ram_addr_w'(i_adr) : '0;

    // fetch wins a tie with the data port
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            gnt_d <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (i_req) begin
                        gnt_d <= 1'b0;
                        state <= st_access;
                    end else if (d_req) begin
                        gnt_d <= 1'b1;
                        state <= st_access;
                    end
                end
                st_access: state <= st_done;
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        ram_en = 1'b0;
        ram_we = 1'b0;
        ram_addr = fetch_addr;
        ram_wdata = d_dat_w;
        io_we = 1'b0;
        pix_we = 1'b0;
        if (state == st_access) begin
            if (!gnt_d) begin
                ram_en = 1'b1;
            end else if (d_is_mem) begin
                ram_en = 1'b1;
                ram_we = d_we;
                ram_addr = ram_addr_w'(d_adr);
            end else if (d_is_io) begin
                io_we = d_we;
            end else if (d_is_pix) begin
                // third pixel write turns into a memory write
                pix_we = d_we;
                ram_en = pw_write;
                ram_we = pw_write;
                ram_addr = pw_addr;
                ram_wdata = pw_data;
            end
        end
    end

    assign io_off = d_adr - led_first;
    assign io_sel = io_off[3:0];
    assign io_wdata = d_dat_w;
    assign pix_wdata = d_dat_w;

    always_comb begin
        if (d_we) begin
            d_dat_r = '0;
        end else if (d_is_mem) begin
            d_dat_r = ram_rdata;
        end else if (d_is_io) begin
            d_dat_r = io_rdata;
        end else begin
            d_dat_r = '0;
        end
    end

    assign i_dat_r = ram_rdata;
    assign i_ack = (state == st_done) && !gnt_d;
    assign d_ack = (state == st_done) && gnt_d;

    a_one_ack: assert property (
        @(posedge clk) disable iff (!rst)
        !(i_ack && d_ack)
    );

    // masters must hold the request until ack
    a_i_ack_req: assert property (
        @(posedge clk) disable iff (!rst)
        i_ack |-> (i_cyc && i_stb)
    );

    a_d_ack_req: assert property (
        @(posedge clk) disable iff (!rst)
        d_ack |-> (d_cyc && d_stb)
    );

endmodule

`default_nettype wire

//--- logic/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    // width of a data word and of a cpu address
    localparam int unsigned word_w = 16;

    // cpu address map of the data port
    // memory words start at 0000
    localparam logic [word_w-1:0] ram_last = 16'hF7FF;

    // one address per led bit, bit 0 of the write data
    localparam logic [word_w-1:0] led_first = 16'hF800;
    localparam int unsigned led_count = 10;

    // read only, bit 0 follows tx_ready
    localparam logic [word_w-1:0] uart_status_adr = 16'hF80A;

    // low byte of the write goes to the uart
    localparam logic [word_w-1:0] uart_byte_adr = 16'hF80B;

    // written three times: x, y, colour
    localparam logic [word_w-1:0] pixel_adr = 16'hF80C;

endpackage

`default_nettype wire

//--- logic/mem_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sys_top import mem_map_pkg::*; #(
    parameter int unsigned x_bits = 6,
    parameter int unsigned y_bits = 5,
    parameter int unsigned ram_addr_w = 17
) (
    input  wire                   clk,
    input  wire                   rst,

    input  wire                   i_cyc,
    input  wire                   i_stb,
    input  wire  [word_w-1:0]     i_adr,
    output logic [word_w-1:0]     i_dat_r,
    output logic                  i_ack,

    input  wire                   d_cyc,
    input  wire                   d_stb,
    input  wire                   d_we,
    input  wire  [word_w-1:0]     d_adr,
    input  wire  [word_w-1:0]     d_dat_w,
    output logic [word_w-1:0]     d_dat_r,
    output logic                  d_ack,

    input  wire                   tx_ready,
    output logic [7:0]            tx_byte,
    output logic                  tx_start_n,

    output logic [led_count-1:0]  led,

    input  wire  [x_bits-1:0]     pix_x,
    input  wire  [y_bits-1:0]     pix_y,
    output logic [word_w-1:0]     pix_data
);

    localparam logic [ram_addr_w-1:0] pix_base = ram_addr_w'(1) << word_w;

    // the pixel grid has to fit between 2^16 and the top of the memory
    if (x_bits + y_bits > word_w || ram_addr_w <= word_w) begin : g_bad_size
        $error("pixel grid does not fit above the cpu space");
    end

    logic                  ram_en;
    logic                  ram_we;
    logic [ram_addr_w-1:0] ram_addr;
    logic [word_w-1:0]     ram_wdata;
    logic [word_w-1:0]     ram_rdata;
    logic                  io_we;
    logic [3:0]            io_sel;
    logic [word_w-1:0]     io_wdata;
    logic [word_w-1:0]     io_rdata;
    logic                  pix_we;
    logic [word_w-1:0]     pix_wdata;
    logic                  pw_write;
    logic [ram_addr_w-1:0] pw_addr;
    logic [word_w-1:0]     pw_data;

    mem_map #(
        .x_bits(x_bits),
        .y_bits(y_bits),
        .ram_addr_w(ram_addr_w)
    ) u_mem_map (
        .clk(clk), .rst(rst),
        .i_cyc(i_cyc), .i_stb(i_stb), .i_adr(i_adr), .i_dat_r(i_dat_r), .i_ack(i_ack),
        .d_cyc(d_cyc), .d_stb(d_stb), .d_we(d_we), .d_adr(d_adr),
        .d_dat_w(d_dat_w), .d_dat_r(d_dat_r), .d_ack(d_ack),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
        .io_we(io_we), .io_sel(io_sel), .io_wdata(io_wdata), .io_rdata(io_rdata),
        .pix_we(pix_we), .pix_wdata(pix_wdata),
        .pw_write(pw_write), .pw_addr(pw_addr), .pw_data(pw_data)
    );

    io_regs u_io_regs (
        .clk(clk), .rst(rst),
        .io_we(io_we), .io_sel(io_sel), .io_wdata(io_wdata), .io_rdata(io_rdata),
        .tx_ready(tx_ready), .tx_byte(tx_byte), .tx_start_n(tx_start_n),
        .led(led)
    );

    pixel_writer #(
        .x_bits(x_bits),
        .y_bits(y_bits),
        .ram_addr_w(ram_addr_w)
    ) u_pixel_writer (
        .clk(clk), .rst(rst),
        .pix_we(pix_we), .pix_wdata(pix_wdata),
        .pw_write(pw_write), .pw_addr(pw_addr), .pw_data(pw_data)
    );

    word_ram #(
        .ram_addr_w(ram_addr_w)
    ) u_word_ram (
        .clk(clk),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
        .scan_addr(pix_base + ram_addr_w'({pix_y, pix_x})),
        .scan_data(pix_data)
    );

endmodule

`default_nettype wire

//--- logic/pixel_writer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_writer import mem_map_pkg::*; #(
    parameter int unsigned x_bits = 6,
    parameter int unsigned y_bits = 5,
    parameter int unsigned ram_addr_w = 17
) (
    input  wire                   clk,
    input  wire                   rst,

    input  wire                   pix_we,
    input  wire  [word_w-1:0]     pix_wdata,

    // memory write request, valid in the strobe cycle
    output logic                  pw_write,
    output logic [ram_addr_w-1:0] pw_addr,
    output logic [word_w-1:0]     pw_data
);

    localparam logic [1:0] step_x = 2'd0;
    localparam logic [1:0] step_y = 2'd1;
    localparam logic [1:0] step_c = 2'd2;

    // pixel region starts right above the cpu space
    localparam logic [ram_addr_w-1:0] pix_base = ram_addr_w'(1) << word_w;

    logic [1:0]        step;
    logic [x_bits-1:0] x_q;
    logic [y_bits-1:0] y_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            step <= step_x;
        end else if (pix_we) begin
            case (step)
                step_x: step <= step_y;
                step_y: step <= step_c;
                default: step <= step_x;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pix_we && step == step_x) begin
            x_q <= pix_wdata[x_bits-1:0];
        end
        if (pix_we && step == step_y) begin
            y_q <= pix_wdata[y_bits-1:0];
        end
    end

    assign pw_write = pix_we && (step == step_c);
    assign pw_addr = pix_base + ram_addr_w'({y_q, x_q});
    assign pw_data = pix_wdata;

    a_step_valid: assert property (
        @(posedge clk) disable iff (!rst)
        step != 2'd3
    );

endmodule

`default_nettype wire

//--- logic/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

// on-chip stand-in for the dram, cpu space at the bottom,
// pixel region from 2^16 upwards
module word_ram import mem_map_pkg::*; #(
    parameter int unsigned ram_addr_w = 17
) (
    input  wire                   clk,

    // port a, read/write for the sequencer
    input  wire                   ram_en,
    input  wire                   ram_we,
    input  wire  [ram_addr_w-1:0] ram_addr,
    input  wire  [word_w-1:0]     ram_wdata,
    output logic [word_w-1:0]     ram_rdata,

    // port b, read only for the display scan
    input  wire  [ram_addr_w-1:0] scan_addr,
    output logic [word_w-1:0]     scan_data
);

    localparam int unsigned depth = 1 << ram_addr_w;

    logic [word_w-1:0] mem [0:depth-1];

    // port a is read-first: a write returns the old word
    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end
            ram_rdata <= mem[ram_addr];
        end
    end

    // scan port reads every cycle
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

endmodule

`default_nettype wire
